//--- hdl/cpuPkg.sv
package cpuPkg;

   localparam int wordWidth   = 32;
   localparam int regSelWidth = 4;   // sixteen general registers

   typedef enum logic [3:0] {
      opAdd,
      opSub,
      opAnd,
      opOr,
      opShl,
      opShr,
      opNeg,
      opNot,
      opMul,   // iterative, 32 cycles
      opDiv    // iterative, 32 cycles
   } aluOpT;

   typedef enum logic [3:0] {
      srcNone,
      srcReg,
      srcPc,
      srcIr,
      srcY,
      srcZLo,
      srcZHi,
      srcMar,
      srcHi,
      srcLo,
      srcMdr,
      srcConst   // sign-extended immediate from IR
   } busSrcT;

   typedef struct packed {
      busSrcT busSrc;
      logic   regIn;
      logic   pcIn;
      logic   irIn;
      logic   yIn;
      logic   zIn;
      logic   marIn;
      logic   hiIn;
      logic   loIn;
      logic   mdrIn;
      logic   memRead;   // MDR takes memDataIn instead of the bus
      logic   gra;
      logic   grb;
      logic   grc;
   } controlWordT;

   // register format and immediate format share the opcode and ra/rb positions
   typedef union packed {
      struct packed {
         logic [4:0]             opcode;
         logic [regSelWidth-1:0] ra;
         logic [regSelWidth-1:0] rb;
         logic [regSelWidth-1:0] rc;
         logic [14:0]            unused;
      } rFmt;
      struct packed {
         logic [4:0]             opcode;
         logic [regSelWidth-1:0] ra;
         logic [regSelWidth-1:0] rb;
         logic [18:0]            constant;
      } iFmt;
   } instrT;

   typedef struct packed {
      logic [wordWidth-1:0] hi;
      logic [wordWidth-1:0] lo;
   } zPairT;

endpackage

//--- hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
   input  logic                            Clock,
   input  logic                            rst,
   input  logic [cpuPkg::regSelWidth-1:0]  regSel,
   input  logic                            regIn,
   input  logic [cpuPkg::wordWidth-1:0]    busValue,
   output logic [cpuPkg::wordWidth-1:0]    readValue
);

   logic [cpuPkg::wordWidth-1:0] regs [2**cpuPkg::regSelWidth];

   // single write port, loaded from the bus
   always_ff @(posedge Clock) begin
      if (rst) begin
         for (int i = 0; i < 2**cpuPkg::regSelWidth; i++) begin
            regs[i] <= '0;
         end
      end else if (regIn) begin
         regs[regSel] <= busValue;
      end
   end

   // combinational read of the same selected register
   assign readValue = regs[regSel];

endmodule

//--- hdl/selectEncode.sv
`timescale 1ns/1ps

module selectEncode (
   input  cpuPkg::instrT                   irValue,
   input  logic                            gra,
   input  logic                            grb,
   input  logic                            grc,
   output logic [cpuPkg::regSelWidth-1:0]  regSel,
   output logic [cpuPkg::wordWidth-1:0]    constValue
);

   localparam int constWidth = $bits(irValue.iFmt.constant);

   // register number from the register-format view
   always_comb begin
      if (gra) begin
         regSel = irValue.rFmt.ra;
      end else if (grb) begin
         regSel = irValue.rFmt.rb;
      end else if (grc) begin
         regSel = irValue.rFmt.rc;
      end else begin
         regSel = '0;   // nothing selected, fall back to R0
      end
   end

   // immediate view, constant sign-extended to a full word
   assign constValue = {{(cpuPkg::wordWidth - constWidth){irValue.iFmt.constant[constWidth-1]}},
                        irValue.iFmt.constant};

endmodule

//--- hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
   input  logic                          Clock,
   input  logic                          rst,
   input  logic                          start,
   input  cpuPkg::aluOpT                 aluOp,
   input  logic [cpuPkg::wordWidth-1:0]  operandA,
   input  logic [cpuPkg::wordWidth-1:0]  operandB,
   output cpuPkg::zPairT                 result,
   output logic                          finished
);

   localparam int w = cpuPkg::wordWidth;

   logic          busy;
   logic          isDiv;
   logic [4:0]    count;      // iteration counter for mul and div
   logic [w-1:0]  operand;    // multiplicand or divisor
   cpuPkg::zPairT acc;        // {hi, lo} working pair
   cpuPkg::zPairT iterIn;
   cpuPkg::zPairT stepped;
   logic [w-1:0]  iterOperand;
   logic          iterDiv;
   logic [w-1:0]  singleResult;

   // shift-add, one multiplier bit per step
   function automatic cpuPkg::zPairT mulStep(input cpuPkg::zPairT p, input logic [w-1:0] m);
      logic [w:0] sum;
      sum = {1'b0, p.hi} + (p.lo[0] ? {1'b0, m} : '0);
      return {sum, p.lo[w-1:1]};
   endfunction

   // restoring division, hi holds the partial remainder and lo shifts the quotient in
   function automatic cpuPkg::zPairT divStep(input cpuPkg::zPairT p, input logic [w-1:0] d);
      logic [w:0]    remShift;
      logic [w:0]    diff;
      cpuPkg::zPairT next;
      remShift = {p.hi, p.lo[w-1]};
      diff     = remShift - {1'b0, d};
      if (!diff[w]) begin
         next = {diff[w-1:0], p.lo[w-2:0], 1'b1};
      end else begin
         next = {remShift[w-1:0], p.lo[w-2:0], 1'b0};   // restore
      end
      return next;
   endfunction

   // first step runs on the start edge straight from the operands
   always_comb begin
      iterDiv     = busy ? isDiv : (aluOp == cpuPkg::opDiv);
      iterOperand = busy ? operand : (iterDiv ? operandB : operandA);
      iterIn      = busy ? acc : {{w{1'b0}}, (iterDiv ? operandA : operandB)};
      stepped     = iterDiv ? divStep(iterIn, iterOperand) : mulStep(iterIn, iterOperand);
   end

   always_comb begin
      case (aluOp)
         cpuPkg::opAdd: singleResult = operandA + operandB;
         cpuPkg::opSub: singleResult = operandA - operandB;
         cpuPkg::opAnd: singleResult = operandA & operandB;
         cpuPkg::opOr:  singleResult = operandA | operandB;
         cpuPkg::opShl: singleResult = operandA << operandB[4:0];
         cpuPkg::opShr: singleResult = operandA >> operandB[4:0];   // logical
         cpuPkg::opNeg: singleResult = -operandA;
         cpuPkg::opNot: singleResult = ~operandA;
         default:       singleResult = '0;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         busy     <= 1'b0;
         isDiv    <= 1'b0;
         count    <= '0;
         finished <= 1'b0;
         result   <= '0;
      end else begin
         finished <= 1'b0;   // pulse
         if (busy) begin
            acc   <= stepped;
            count <= count + 5'd1;
            if (count == 5'd31) begin
               result   <= stepped;
               finished <= 1'b1;
               busy     <= 1'b0;
            end
         end else if (start) begin
            if (aluOp == cpuPkg::opMul || aluOp == cpuPkg::opDiv) begin
               busy    <= 1'b1;
               isDiv   <= iterDiv;
               operand <= iterOperand;
               acc     <= stepped;
               count   <= 5'd1;
            end else begin
               result   <= {{w{1'b0}}, singleResult};
               finished <= 1'b1;
            end
         end
      end
   end

endmodule

//--- hdl/specialRegs.sv
`timescale 1ns/1ps

module specialRegs (
   input  logic                          Clock,
   input  logic                          rst,
   input  cpuPkg::controlWordT           ctrl,
   input  logic [cpuPkg::wordWidth-1:0]  regValue,
   input  logic [cpuPkg::wordWidth-1:0]  constValue,
   input  cpuPkg::zPairT                 aluResult,
   input  logic                          finished,
   input  logic [cpuPkg::wordWidth-1:0]  memDataIn,
   output logic [cpuPkg::wordWidth-1:0]  busValue,
   output logic [cpuPkg::wordWidth-1:0]  yValue,
   output cpuPkg::instrT                 irValue,
   output logic [cpuPkg::wordWidth-1:0]  memAddr,
   output logic [cpuPkg::wordWidth-1:0]  memDataOut
);

   logic [cpuPkg::wordWidth-1:0] pc;
   logic [cpuPkg::wordWidth-1:0] hi;
   logic [cpuPkg::wordWidth-1:0] lo;
   logic [cpuPkg::wordWidth-1:0] mar;
   logic [cpuPkg::wordWidth-1:0] mdr;
   cpuPkg::zPairT                z;
   cpuPkg::instrT                ir;
   logic [cpuPkg::wordWidth-1:0] y;

   always_ff @(posedge Clock) begin
      if (rst) begin
         pc  <= '0;
         ir  <= '0;
         y   <= '0;
         z   <= '0;
         hi  <= '0;
         lo  <= '0;
         mar <= '0;
         mdr <= '0;
      end else begin
         if (ctrl.pcIn)  pc  <= busValue;
         if (ctrl.irIn)  ir  <= busValue;
         if (ctrl.yIn)   y   <= busValue;
         if (ctrl.hiIn)  hi  <= busValue;
         if (ctrl.loIn)  lo  <= busValue;
         if (ctrl.marIn) mar <= busValue;
         // Z only takes the ALU result once it is valid
         if (ctrl.zIn && finished) z <= aluResult;
         if (ctrl.mdrIn) begin
            mdr <= ctrl.memRead ? memDataIn : busValue;
         end
      end
   end

   // one source on the bus per cycle
   always_comb begin
      case (ctrl.busSrc)
         cpuPkg::srcReg:   busValue = regValue;
         cpuPkg::srcPc:    busValue = pc;
         cpuPkg::srcIr:    busValue = ir;
         cpuPkg::srcY:     busValue = y;
         cpuPkg::srcZLo:   busValue = z.lo;
         cpuPkg::srcZHi:   busValue = z.hi;
         cpuPkg::srcMar:   busValue = mar;
         cpuPkg::srcHi:    busValue = hi;
         cpuPkg::srcLo:    busValue = lo;
         cpuPkg::srcMdr:   busValue = mdr;
         cpuPkg::srcConst: busValue = constValue;
         default:          busValue = '0;   // srcNone
      endcase
   end

   assign yValue     = y;
   assign irValue    = ir;
   assign memAddr    = mar;
   assign memDataOut = mdr;

endmodule

//--- hdl/dataPath.sv
`timescale 1ns/1ps

module dataPath (
   input  logic                          Clock,
   input  logic                          rst,
   input  cpuPkg::controlWordT           ctrl,
   input  cpuPkg::aluOpT                 aluOp,
   input  logic                          start,
   input  logic [cpuPkg::wordWidth-1:0]  memDataIn,
   output logic                          finished,
   output logic [cpuPkg::wordWidth-1:0]  memAddr,
   output logic [cpuPkg::wordWidth-1:0]  memDataOut
);

   logic [cpuPkg::wordWidth-1:0]   busValue;
   logic [cpuPkg::wordWidth-1:0]   regValue;
   logic [cpuPkg::wordWidth-1:0]   constValue;
   logic [cpuPkg::wordWidth-1:0]   yValue;
   logic [cpuPkg::regSelWidth-1:0] regSel;
   cpuPkg::instrT                  irValue;
   cpuPkg::zPairT                  aluResult;

   registerFile regs (
      .Clock     (Clock),
      .rst       (rst),
      .regSel    (regSel),
      .regIn     (ctrl.regIn),
      .busValue  (busValue),
      .readValue (regValue)
   );

   // register number and immediate both come from IR
   selectEncode encoder (
      .irValue    (irValue),
      .gra        (ctrl.gra),
      .grb        (ctrl.grb),
      .grc        (ctrl.grc),
      .regSel     (regSel),
      .constValue (constValue)
   );

   aluUnit alu (
      .Clock    (Clock),
      .rst      (rst),
      .start    (start),
      .aluOp    (aluOp),
      .operandA (yValue),     // Y is always operand A
      .operandB (busValue),
      .result   (aluResult),
      .finished (finished)
   );

   specialRegs special (
      .Clock      (Clock),
      .rst        (rst),
      .ctrl       (ctrl),
      .regValue   (regValue),
      .constValue (constValue),
      .aluResult  (aluResult),
      .finished   (finished),
      .memDataIn  (memDataIn),
      .busValue   (busValue),
      .yValue     (yValue),
      .irValue    (irValue),
      .memAddr    (memAddr),
      .memDataOut (memDataOut)
   );

endmodule

//--- verif/dataPathTb.sv
`timescale 1ns/1ps

module dataPathTb;

   localparam int numTests       = 5;
   localparam int watchdogCycles = numTests * 100 + 200;

   // enable bits in control word order below busSrc
   localparam logic [12:0] ldReg = 13'h1000;
   localparam logic [12:0] ldPc  = 13'h0800;
   localparam logic [12:0] ldIr  = 13'h0400;
   localparam logic [12:0] ldY   = 13'h0200;
   localparam logic [12:0] ldZ   = 13'h0100;
   localparam logic [12:0] ldMar = 13'h0080;
   localparam logic [12:0] ldHi  = 13'h0040;
   localparam logic [12:0] ldLo  = 13'h0020;
   localparam logic [12:0] ldMdr = 13'h0010;
   localparam logic [12:0] memRd = 13'h0008;
   localparam logic [12:0] selA  = 13'h0004;
   localparam logic [12:0] selB  = 13'h0002;

   logic                Clock = 1'b0;
   logic                rst;
   cpuPkg::controlWordT ctrl;
   cpuPkg::aluOpT       aluOp;
   logic                start;
   logic [31:0]         memDataIn;
   logic                finished;
   logic [31:0]         memAddr;
   logic [31:0]         memDataOut;

   dataPath uut (
      .Clock      (Clock),
      .rst        (rst),
      .ctrl       (ctrl),
      .aluOp      (aluOp),
      .start      (start),
      .memDataIn  (memDataIn),
      .finished   (finished),
      .memAddr    (memAddr),
      .memDataOut (memDataOut)
   );

   always #20 Clock = ~Clock;

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else
         failRun($sformatf("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp));
   endtask

   // one control word that takes effect on the following edge
   task automatic transfer(input cpuPkg::busSrcT src, input logic [12:0] enables);
      @(posedge Clock);
      ctrl <= cpuPkg::controlWordT'({src, enables});
   endtask

   task automatic loadMdr(input logic [31:0] value);
      transfer(cpuPkg::srcNone, ldMdr | memRd);
      memDataIn <= value;
   endtask

   task automatic sampleMdr(output logic [31:0] value);
      transfer(cpuPkg::srcNone, 13'h0);
      @(negedge Clock);
      value = memDataOut;
   endtask

   task automatic setIr(input logic [31:0] word);
      loadMdr(word);
      transfer(cpuPkg::srcMdr, ldIr);
   endtask

   task automatic loadReg(input logic [3:0] idx, input logic [31:0] value);
      setIr({5'd0, 4'd0, idx, 19'd0});   // rb names the target
      loadMdr(value);
      transfer(cpuPkg::srcMdr, ldReg | selB);
   endtask

   task automatic readReg(input logic [3:0] idx, output logic [31:0] value);
      setIr({5'd0, 4'd0, idx, 19'd0});
      transfer(cpuPkg::srcReg, ldMdr | selB);
      sampleMdr(value);
   endtask

   // zIn stays high until the edge after finished
   task automatic runAlu(input cpuPkg::aluOpT op, input cpuPkg::busSrcT src, output int cycles);
      transfer(src, ldZ);
      aluOp <= op;
      start <= 1'b1;
      transfer(cpuPkg::srcNone, ldZ);
      start  <= 1'b0;
      cycles = 1;
      @(negedge Clock);
      while (!finished && cycles < 40) begin
         @(negedge Clock);
         cycles++;
      end
      assert (finished) else failRun("ALU never raised finished within 40 cycles of start");
   endtask

   function automatic logic [31:0] singleExpected(input cpuPkg::aluOpT op,
                                                  input logic [31:0] a, input logic [31:0] b);
      logic [31:0] shifted;
      shifted = a;
      // shift one place at a time
      for (int k = 0; k < int'(b[4:0]); k++) begin
         shifted = (op == cpuPkg::opShl) ? {shifted[30:0], 1'b0} : {1'b0, shifted[31:1]};
      end
      case (op)
         cpuPkg::opAdd: return a + b;
         cpuPkg::opSub: return a + ~b + 32'd1;
         cpuPkg::opAnd: return a & b;
         cpuPkg::opOr:  return a | b;
         cpuPkg::opShl: return shifted;
         cpuPkg::opShr: return shifted;
         default:       return ~a + 32'd1;   // negate
      endcase
   endfunction

   task automatic resetState();
      logic [31:0] pcValue;
      pcValue = $urandom;
      checkValue("memAddr after reset", memAddr, 32'h0);
      checkValue("memDataOut after reset", memDataOut, 32'h0);
      checkValue("finished after reset", {31'd0, finished}, 32'h0);
      loadMdr(pcValue);
      transfer(cpuPkg::srcMdr, ldPc);
      transfer(cpuPkg::srcPc, ldMar);
      transfer(cpuPkg::srcNone, 13'h0);
      @(negedge Clock);
      checkValue("memAddr from PC", memAddr, pcValue);
   endtask

   task automatic notInstruction();
      logic [31:0] got;
      int          cycles;
      loadReg(4'd7, 32'h12);
      loadReg(4'd6, 32'h18);
      setIr(32'h93B00000);   // opcode 18, ra 7, rb 6
      transfer(cpuPkg::srcReg, ldMdr | selB);
      sampleMdr(got);
      checkValue("rb field selects R6", got, 32'h18);
      transfer(cpuPkg::srcReg, ldY | selB);
      runAlu(cpuPkg::opNot, cpuPkg::srcNone, cycles);
      checkValue("opNot latency", cycles, 32'd1);
      transfer(cpuPkg::srcZLo, ldReg | selA);
      readReg(4'd7, got);
      checkValue("not of R6 stored in R7", got, 32'hFFFFFFE7);
   endtask

   task automatic singleCycleOps();
      cpuPkg::aluOpT ops [7];
      logic [31:0]   a;
      logic [31:0]   b;
      logic [31:0]   got;
      int            cycles;
      ops = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
              cpuPkg::opShl, cpuPkg::opShr, cpuPkg::opNeg};
      for (int i = 0; i < 7; i++) begin
         a = $urandom;
         b = $urandom;
         loadMdr(a);
         transfer(cpuPkg::srcMdr, ldY);
         loadMdr(b);
         runAlu(ops[i], cpuPkg::srcMdr, cycles);
         checkValue($sformatf("%s latency", ops[i].name()), cycles, 32'd1);
         transfer(cpuPkg::srcZLo, ldMdr);
         sampleMdr(got);
         checkValue($sformatf("%s result", ops[i].name()), got, singleExpected(ops[i], a, b));
         transfer(cpuPkg::srcZHi, ldMdr);
         sampleMdr(got);
         checkValue($sformatf("%s high word", ops[i].name()), got, 32'h0);
      end
   endtask

   // Z.hi goes out through HI and Z.lo through LO
   task automatic checkLong(input cpuPkg::aluOpT op, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] expHi, input logic [31:0] expLo);
      logic [31:0] got;
      int          cycles;
      loadMdr(a);
      transfer(cpuPkg::srcMdr, ldY);
      loadMdr(b);
      runAlu(op, cpuPkg::srcMdr, cycles);
      checkValue($sformatf("%s latency", op.name()), cycles, 32'd32);
      transfer(cpuPkg::srcZHi, ldHi);
      transfer(cpuPkg::srcZLo, ldLo);
      transfer(cpuPkg::srcHi, ldMdr);
      sampleMdr(got);
      checkValue($sformatf("%s HI", op.name()), got, expHi);
      transfer(cpuPkg::srcLo, ldMdr);
      sampleMdr(got);
      checkValue($sformatf("%s LO", op.name()), got, expLo);
   endtask

   task automatic multiplyDivide();
      logic [63:0] product;
      logic [31:0] a;
      logic [31:0] b;
      repeat (2) begin
         a = $urandom;
         b = $urandom;
         product = {32'd0, a} * {32'd0, b};
         checkLong(cpuPkg::opMul, a, b, product[63:32], product[31:0]);
      end
      a = $urandom;
      b = $urandom | 32'h1;   // never zero
      checkLong(cpuPkg::opDiv, a, b, a % b, a / b);
      b = ($urandom % 1000) + 1;
      checkLong(cpuPkg::opDiv, a, b, a % b, a / b);
      checkLong(cpuPkg::opDiv, a, 32'd0, a, 32'hFFFFFFFF);
   endtask

   task automatic immediatePath();
      logic [18:0] imm;
      logic [31:0] base;
      logic [31:0] extended;
      logic [31:0] got;
      int          cycles;
      imm      = {1'b1, 18'($urandom)};   // sign bit set
      extended = {{13{1'b1}}, imm};
      base     = $urandom;
      loadReg(4'd4, base);
      setIr({5'd3, 4'd4, 4'd0, imm});
      transfer(cpuPkg::srcConst, ldMdr);
      sampleMdr(got);
      checkValue("sign-extended constant", got, extended);
      transfer(cpuPkg::srcReg, ldY | selA);
      runAlu(cpuPkg::opAdd, cpuPkg::srcConst, cycles);
      checkValue("immediate add latency", cycles, 32'd1);
      transfer(cpuPkg::srcZLo, ldReg | selA);
      readReg(4'd4, got);
      checkValue("register plus constant", got, base + extended);
   endtask

   initial begin
      repeat (watchdogCycles) @(posedge Clock);
      failRun("watchdog expired before the tests completed");
   end

   initial begin
      void'($urandom(32'h1e5d61b0));
      rst       = 1'b1;
      ctrl      = '0;
      aluOp     = cpuPkg::opAdd;
      start     = 1'b0;
      memDataIn = '0;
      repeat (4) @(posedge Clock);
      rst <= 1'b0;
      @(negedge Clock);
      resetState();
      notInstruction();
      singleCycleOps();
      multiplyDivide();
      immediatePath();
      $display("All tests passed!");
      $finish;
   end

endmodule

//--- sim.f
hdl/cpuPkg.sv
hdl/registerFile.sv
hdl/selectEncode.sv
hdl/aluUnit.sv
hdl/specialRegs.sv
hdl/dataPath.sv
verif/dataPathTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dataPathTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
